// File: bench/lsu_ref_model.svh
// Reference rules for byte enables, write data and load results, included inside lsu_tb
`ifndef LSU_REF_MODEL_SVH
`define LSU_REF_MODEL_SVH

  // Bytes moved by one access
  function automatic int size_bytes(input lsu_pkg::lsu_size_e size);
    case (size)
      lsu_pkg::SIZE_BYTE: return 1;
      lsu_pkg::SIZE_HALF: return 2;
      default:            return 4;
    endcase
  endfunction

  // Lanes touched by the first transfer, or by the second one of a split
  function automatic logic [3:0] model_be(input logic [1:0] off, input int nbytes,
                                          input logic second);
    logic [3:0] be;
    int         lane;
    be = 4'b0000;
    for (int i = 0; i < nbytes; i++) begin
      lane = int'(off) + i;
      if (second && lane >= 4) begin
        be[lane-4] = 1'b1;
      end else if (!second && lane < 4) begin
        be[lane] = 1'b1;
      end
    end
    return be;
  endfunction

  // Store byte i lands on lane (offset + i) mod 4
  function automatic logic [31:0] model_wdata(input logic [31:0] wd, input logic [1:0] off);
    logic [31:0] r;
    logic [1:0]  lane;
    for (int i = 0; i < 4; i++) begin
      lane = off + 2'(i);
      r[8*lane +: 8] = wd[8*i +: 8];
    end
    return r;
  endfunction

  // Little endian gather from byte memory, then zero or sign extension
  function automatic logic [31:0] model_load(input logic [7:0] mem [256], input logic [31:0] addr,
                                             input int nbytes, input logic sext);
    logic [31:0] v;
    logic [7:0]  idx;
    v = '0;
    for (int i = 0; i < nbytes; i++) begin
      idx = 8'(addr + 32'(i));
      v[8*i +: 8] = mem[idx];
    end
    if (sext && nbytes < 4 && v[8*nbytes-1]) begin
      v = v | ~((32'd1 << (8 * nbytes)) - 32'd1);
    end
    return v;
  endfunction

`endif

// File: bench/lsu_tb.sv
// Testbench for lsu_top with random core accesses, a bus memory responder, model checks and a watchdog
`timescale 1ns/1ps

module lsu_tb;

  import lsu_pkg::*;

  localparam int NUM_OPS    = 400;
  localparam int CLK_PERIOD = 8;

  logic      clk, rst_n;
  logic      valid_0_i, we_i, sext_i;
  addr_t     op_a_i, op_b_i;
  word_t     wdata_i;
  lsu_size_e size_i;
  logic      ready_0_o, split_0_o, first_op_0_o, last_op_0_o;
  logic      valid_1_o, last_1_o;
  word_t     rdata_1_o;
  logic      busy_o, interruptible_o, protocol_err_o;
  logic      data_req_o, data_gnt_i, data_we_o, data_rvalid_i;
  addr_t     data_addr_o;
  be_t       data_be_o;
  word_t     data_wdata_o, data_rdata_i;

  // Random source plus byte memories for the bus side and the model side
  logic [31:0] lfsr;
  logic [7:0]  resp_mem [256];
  logic [7:0]  model_mem [256];

  // Responses waiting on the bus and expectations per granted transfer
  word_t rsp_data_q [$];
  int    rsp_due_q [$];
  logic  exp_last_q [$];
  logic  exp_load_q [$];
  word_t exp_data_q [$];

  int    cyc, last_due, out_cnt, ops_issued, ops_done, phase, n_phase;
  logic  running, op_active, stall_q;
  addr_t exp_addr [2];
  be_t   exp_be [2];
  word_t exp_wdata, exp_load;
  // Request fields seen in a stalled cycle
  addr_t hold_addr;
  be_t   hold_be;
  word_t hold_wdata;
  logic  hold_we;

  `include "lsu_ref_model.svh"

  lsu_top UUT (.*);

  initial clk = 1'b0;
  always #(CLK_PERIOD / 2) clk = ~clk;

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  // One LFSR step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      v = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
    if (got !== exp) begin
      $display("Error at %0d ns: %s is %h, expected %h", $time, what, got, exp);
      $display("ERRORS FOUND");
      $fatal(1, "Stopped at first mismatch");
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Falling edge drivers
  ////////////////////////////////////////////////////////////////////////////

  // Random grant with in order responses once due
  task automatic drive_bus();
    data_gnt_i = (rand_bits(2) != 32'd0);
    if (rsp_due_q.size() != 0 && rsp_due_q[0] <= cyc) begin
      data_rvalid_i = 1'b1;
      data_rdata_i  = rsp_data_q[0];
    end else begin
      data_rvalid_i = 1'b0;
      data_rdata_i  = '0;
    end
  endtask

  // New access only once the previous one has left EX
  task automatic drive_core();
    int         nb;
    addr_t      addr;
    logic [1:0] sel;
    if (op_active) begin
      return;
    end
    if (ops_issued == NUM_OPS || rand_bits(2) == 32'd0) begin
      valid_0_i = 1'b0;
      return;
    end
    we_i      = 1'(rand_bits(1));
    sext_i    = 1'(rand_bits(1));
    sel       = 2'(rand_bits(2));
    size_i    = (sel == 2'd3) ? SIZE_WORD : lsu_size_e'(sel);
    op_a_i    = rand_bits(8);
    op_b_i    = rand_bits(4);
    wdata_i   = rand_bits(32);
    valid_0_i = 1'b1;
    addr      = op_a_i + op_b_i;
    nb        = size_bytes(size_i);
    // Access past the end of its word needs a second transfer
    n_phase     = (int'(addr[1:0]) + nb > 4) ? 2 : 1;
    phase       = 0;
    exp_addr[0] = addr;
    exp_addr[1] = {addr[31:2], 2'b00} + 32'd4;
    exp_be[0]   = model_be(addr[1:0], nb, 1'b0);
    exp_be[1]   = model_be(addr[1:0], nb, 1'b1);
    exp_wdata   = model_wdata(wdata_i, addr[1:0]);
    exp_load    = model_load(model_mem, addr, nb, sext_i);
    if (we_i) begin
      for (int i = 0; i < nb; i++) begin
        model_mem[8'(addr + 32'(i))] = wdata_i[8*i +: 8];
      end
    end
    op_active  = 1'b1;
    ops_issued = ops_issued + 1;
  endtask

  always @(negedge clk) begin
    if (running) begin
      drive_bus();
      drive_core();
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Rising edge monitor and bus memory
  ////////////////////////////////////////////////////////////////////////////

  task automatic watch_cycle();
    int    due;
    logic  last;
    word_t rd;
    check_eq(protocol_err_o, 1'b0, "protocol_err_o");
    check_eq(valid_1_o, data_rvalid_i, "valid_1_o");
    // Request follows valid until two transfers wait for data
    check_eq(data_req_o, valid_0_i && (out_cnt < 2), "data_req_o");
    if (out_cnt != 0) begin
      check_eq(busy_o, 1'b1, "busy_o with transfers outstanding");
    end
    if (!valid_0_i && out_cnt == 0) begin
      check_eq(busy_o, 1'b0, "busy_o when idle");
      check_eq(interruptible_o, 1'b1, "interruptible_o when idle");
    end
    // Stalled request must hold its fields
    if (stall_q) begin
      check_eq(data_req_o, 1'b1, "data_req_o after stall");
      check_eq(data_addr_o, hold_addr, "data_addr_o during stall");
      check_eq(data_be_o, hold_be, "data_be_o during stall");
      check_eq(data_wdata_o, hold_wdata, "data_wdata_o during stall");
      check_eq(data_we_o, hold_we, "data_we_o during stall");
      check_eq(interruptible_o, 1'b0, "interruptible_o during stall");
    end
    if (data_req_o && !data_gnt_i) begin
      check_eq(ready_0_o, 1'b0, "ready_0_o without grant");
    end
    stall_q    = data_req_o && !data_gnt_i;
    hold_addr  = data_addr_o;
    hold_be    = data_be_o;
    hold_wdata = data_wdata_o;
    hold_we    = data_we_o;

    if (data_rvalid_i) begin
      check_eq(last_1_o, exp_last_q[0], "last_1_o");
      if (exp_load_q[0]) begin
        check_eq(rdata_1_o, exp_data_q[0], "load result");
      end
      void'(exp_last_q.pop_front());
      void'(exp_load_q.pop_front());
      void'(exp_data_q.pop_front());
      void'(rsp_data_q.pop_front());
      void'(rsp_due_q.pop_front());
      out_cnt = out_cnt - 1;
    end

    if (data_req_o && data_gnt_i) begin
      last = (phase == n_phase - 1);
      check_eq(data_addr_o, exp_addr[phase], "data_addr_o");
      check_eq(data_be_o, exp_be[phase], "data_be_o");
      if (we_i) begin
        check_eq(data_wdata_o, exp_wdata, "data_wdata_o");
      end
      check_eq(ready_0_o, last, "ready_0_o at accept");
      check_eq(split_0_o, phase == 0 && n_phase == 2, "split_0_o");
      check_eq(first_op_0_o, phase == 0, "first_op_0_o");
      check_eq(last_op_0_o, last, "last_op_0_o");
      exp_last_q.push_back(last);
      exp_load_q.push_back(last && !we_i);
      exp_data_q.push_back(exp_load);
      // Memory word behind the granted address
      for (int l = 0; l < 4; l++) begin
        if (data_we_o && data_be_o[l]) begin
          resp_mem[{data_addr_o[7:2], 2'(l)}] = data_wdata_o[8*l +: 8];
        end
        rd[8*l +: 8] = resp_mem[{data_addr_o[7:2], 2'(l)}];
      end
      // Latency of 1 to 3 cycles kept in order
      due = cyc + ((rand_bits(2) == 32'd0) ? 3 : int'(rand_bits(1)) + 1);
      if (due <= last_due) begin
        due = last_due + 1;
      end
      last_due = due;
      rsp_data_q.push_back(rd);
      rsp_due_q.push_back(due);
      out_cnt = out_cnt + 1;
      check_eq(out_cnt > 2, 1'b0, "outstanding transfers above 2");
      phase = phase + 1;
    end

    if (valid_0_i && ready_0_o) begin
      op_active = 1'b0;
      ops_done  = ops_done + 1;
    end
  endtask

  always @(posedge clk) begin
    if (running) begin
      watch_cycle();
      cyc = cyc + 1;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Sequence and watchdog
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    lfsr          = 32'h4470;
    rst_n         = 1'b0;
    valid_0_i     = 1'b0;
    op_a_i        = '0;
    op_b_i        = '0;
    wdata_i       = '0;
    we_i          = 1'b0;
    size_i        = SIZE_BYTE;
    sext_i        = 1'b0;
    data_gnt_i    = 1'b0;
    data_rvalid_i = 1'b0;
    data_rdata_i  = '0;
    running       = 1'b0;
    op_active     = 1'b0;
    stall_q       = 1'b0;
    cyc           = 0;
    last_due      = 0;
    out_cnt       = 0;
    ops_issued    = 0;
    ops_done      = 0;
    phase         = 0;
    n_phase       = 1;
    for (int i = 0; i < 256; i++) begin
      resp_mem[i]  = 8'(i) ^ 8'hA5;
      model_mem[i] = 8'(i) ^ 8'hA5;
    end
    repeat (10) @(posedge clk);
    @(negedge clk);
    #1 rst_n = 1'b1;
    @(posedge clk);
    check_eq(busy_o, 1'b0, "busy_o after reset");
    check_eq(interruptible_o, 1'b1, "interruptible_o after reset");
    check_eq(protocol_err_o, 1'b0, "protocol_err_o after reset");
    check_eq(valid_1_o, 1'b0, "valid_1_o after reset");
    check_eq(data_req_o, 1'b0, "data_req_o after reset");
    #1 running = 1'b1;
    while (ops_done < NUM_OPS || rsp_due_q.size() != 0 || exp_last_q.size() != 0) begin
      @(negedge clk);
    end
    for (int i = 0; i < 256; i++) begin
      check_eq(resp_mem[i], model_mem[i], $sformatf("memory byte %0d", i));
    end
    $display("NO ERRORS");
    $finish;
  end

  initial begin
    #(NUM_OPS * 20 * CLK_PERIOD);
    $display("Timeout: %0d accesses did not finish within %0d cycles", NUM_OPS, NUM_OPS * 20);
    $display("ERRORS FOUND");
    $fatal(1, "Watchdog expired");
  end

endmodule

// File: logic/lsu_pkg.sv
// Shared widths, access size codes and queue depth for the load/store unit RTL

package lsu_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Widths
  ////////////////////////////////////////////////////////////////////////////

  // Byte address on the data bus
  typedef logic [31:0] addr_t;

  // One data word, bus and register file
  typedef logic [31:0] word_t;

  // One enable per byte lane
  typedef logic [3:0] be_t;

  // Byte position inside a word
  typedef logic [1:0] offset_t;

  ////////////////////////////////////////////////////////////////////////////
  // Access sizes
  ////////////////////////////////////////////////////////////////////////////

  // Encoding follows the funct3 low bits of RISC-V loads and stores
  typedef enum logic [1:0] {
    SIZE_BYTE = 2'd0,
    SIZE_HALF = 2'd1,
    SIZE_WORD = 2'd2
  } lsu_size_e;

  ////////////////////////////////////////////////////////////////////////////
  // Limits
  ////////////////////////////////////////////////////////////////////////////

  // Transfers allowed on the bus without a response
  localparam int unsigned LSU_DEPTH = 2;

endpackage

// File: logic/lsu_req_gen.sv
// EX stage request builder: address, byte enables, rotated write data, split phase tracking
`timescale 1ns/1ps

module lsu_req_gen (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              valid_0_i,
  input  lsu_pkg::addr_t    op_a_i,
  input  lsu_pkg::addr_t    op_b_i,
  input  lsu_pkg::word_t    wdata_i,
  input  lsu_pkg::lsu_size_e size_i,
  input  logic              ex_done_i,
  output lsu_pkg::addr_t    trans_addr_o,
  output lsu_pkg::be_t      trans_be_o,
  output lsu_pkg::word_t    trans_wdata_o,
  output logic              split_0_o,
  output logic              first_op_0_o,
  output logic              last_op_0_o,
  output logic              misaligned_o
);

  import lsu_pkg::*;

  // Effective address and its byte position
  addr_t   addr;
  offset_t offset;
  // Second address phase of a split access in progress
  logic    split_q;

  assign addr   = op_a_i + op_b_i;
  assign offset = addr[1:0];

  ////////////////////////////////////////////////////////////////////////////
  // Split detection
  ////////////////////////////////////////////////////////////////////////////

  // Word not on a word boundary, or halfword crossing into the next word
  always_comb begin
    split_0_o = 1'b0;
    if (valid_0_i && !split_q) begin
      case (size_i)
        SIZE_WORD: split_0_o = (offset != 2'b00);
        SIZE_HALF: split_0_o = (offset == 2'b11);
        default:   split_0_o = 1'b0;
      endcase
    end
  end

  // Held for both phases, also covers the odd halfword that fits one word
  assign misaligned_o = valid_0_i &&
                        (split_q || split_0_o || ((size_i == SIZE_HALF) && offset[0]));

  assign first_op_0_o = !split_q;
  assign last_op_0_o  = !split_0_o;

  // Cleared whenever EX is empty so a killed split cannot leak into the next access
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      split_q <= 1'b0;
    end else if (!valid_0_i) begin
      split_q <= 1'b0;
    end else if (ex_done_i) begin
      split_q <= split_0_o;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Address phase fields
  ////////////////////////////////////////////////////////////////////////////

  // Second half always starts at lane 0 of the next word
  assign trans_addr_o = split_q ? addr_t'({addr[31:2], 2'b00} + 32'd4) : addr;

  always_comb begin
    trans_be_o = 4'b0000;
    case (size_i)
      SIZE_BYTE: trans_be_o = be_t'(4'b0001 << offset);
      SIZE_HALF: begin
        if (split_q) begin
          trans_be_o = 4'b0001;
        end else begin
          // Offset 3 keeps only the top lane here
          trans_be_o = be_t'(4'b0011 << offset);
        end
      end
      default: begin
        if (split_q) begin
          // Lanes left over from the first half
          trans_be_o = be_t'(4'b1111 >> (3'd4 - {1'b0, offset}));
        end else begin
          trans_be_o = be_t'(4'b1111 << offset);
        end
      end
    endcase
  end

  // Rotate left by the byte offset; the upper bytes wrap into the low lanes
  always_comb begin
    case (offset)
      2'b01:   trans_wdata_o = {wdata_i[23:0], wdata_i[31:24]};
      2'b10:   trans_wdata_o = {wdata_i[15:0], wdata_i[31:16]};
      2'b11:   trans_wdata_o = {wdata_i[7:0],  wdata_i[31:8]};
      default: trans_wdata_o = wdata_i;
    endcase
  end

  // A request that can reach the bus must enable at least one lane
  a_be_nonzero: assert property (@(posedge clk) disable iff (!rst_n)
    valid_0_i |-> (trans_be_o != 4'b0000));

endmodule

// File: logic/lsu_resp_align.sv
// Load response path: per-transfer control queue, split-half join, realignment, extension
`timescale 1ns/1ps

module lsu_resp_align #(
  parameter int unsigned depth = lsu_pkg::LSU_DEPTH
) (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               txn_accept_i,
  input  logic               split_0_i,
  input  logic               we_i,
  input  lsu_pkg::lsu_size_e size_i,
  input  logic               sext_i,
  input  lsu_pkg::offset_t   offset_i,
  input  logic               data_rvalid_i,
  input  lsu_pkg::word_t     data_rdata_i,
  output logic               valid_1_o,
  output logic               last_1_o,
  output lsu_pkg::word_t     rdata_1_o
);

  import lsu_pkg::*;

  localparam int unsigned ptr_w = (depth > 1) ? $clog2(depth) : 1;
  localparam int unsigned cnt_w = $clog2(depth + 1);
  localparam logic [ptr_w-1:0] ptr_last = ptr_w'(depth - 1);

  // Control queue, one entry per granted transfer
  lsu_size_e        q_size [depth];
  offset_t          q_off  [depth];
  logic [depth-1:0] q_sext;
  logic [depth-1:0] q_we;
  logic [depth-1:0] q_last;
  logic [ptr_w-1:0] wr_ptr;
  logic [ptr_w-1:0] rd_ptr;
  logic [cnt_w-1:0] q_cnt;
  logic             push;
  logic             pop;

  // Low word of a split load, with the offset of the original access
  word_t            half_q;
  offset_t          half_off_q;
  logic             half_vld_q;

  offset_t          align_off;
  logic [63:0]      rdata_full;
  logic [63:0]      rdata_shift;

  assign push = txn_accept_i;
  assign pop  = data_rvalid_i && (q_cnt != '0);

  ////////////////////////////////////////////////////////////////////////////
  // Control queue
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (push) begin
      q_size[wr_ptr] <= size_i;
      q_off[wr_ptr]  <= offset_i;
      q_sext[wr_ptr] <= sext_i;
      q_we[wr_ptr]   <= we_i;
      // First half of a split never completes the access
      q_last[wr_ptr] <= !split_0_i;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      q_cnt  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == ptr_last) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == ptr_last) ? '0 : rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10:   q_cnt <= q_cnt + 1'b1;
        2'b01:   q_cnt <= q_cnt - 1'b1;
        default: q_cnt <= q_cnt;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Split half capture
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (pop && !q_last[rd_ptr] && !q_we[rd_ptr]) begin
      half_q     <= data_rdata_i;
      half_off_q <= q_off[rd_ptr];
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      half_vld_q <= 1'b0;
    end else if (pop) begin
      half_vld_q <= !q_last[rd_ptr] && !q_we[rd_ptr];
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Realign and extend
  ////////////////////////////////////////////////////////////////////////////

  // Second half arrives word aligned, so shift by the first half's offset
  assign align_off   = half_vld_q ? half_off_q : q_off[rd_ptr];
  assign rdata_full  = half_vld_q ? {data_rdata_i, half_q} : {data_rdata_i, data_rdata_i};
  assign rdata_shift = rdata_full >> {align_off, 3'b000};

  always_comb begin
    case (q_size[rd_ptr])
      SIZE_BYTE: rdata_1_o = {{24{q_sext[rd_ptr] && rdata_shift[7]}}, rdata_shift[7:0]};
      SIZE_HALF: rdata_1_o = {{16{q_sext[rd_ptr] && rdata_shift[15]}}, rdata_shift[15:0]};
      default:   rdata_1_o = rdata_shift[31:0];
    endcase
  end

  // WB never stalls, every response is passed straight on
  assign valid_1_o = data_rvalid_i;
  assign last_1_o  = data_rvalid_i && q_last[rd_ptr];

  // Every response must match a transfer granted in an earlier cycle
  a_pop_nonempty: assert property (@(posedge clk) disable iff (!rst_n)
    data_rvalid_i |-> (q_cnt != '0));

endmodule

// File: logic/lsu_top.sv
// Load/store unit top level that joins the core EX/WB ports to the data bus
`timescale 1ns/1ps

module lsu_top (
  input  logic               clk,
  input  logic               rst_n,
  // Core EX side
  input  logic               valid_0_i,
  input  lsu_pkg::addr_t     op_a_i,
  input  lsu_pkg::addr_t     op_b_i,
  input  lsu_pkg::word_t     wdata_i,
  input  logic               we_i,
  input  lsu_pkg::lsu_size_e size_i,
  input  logic               sext_i,
  output logic               ready_0_o,
  output logic               split_0_o,
  output logic               first_op_0_o,
  output logic               last_op_0_o,
  // Core WB side
  output logic               valid_1_o,
  output logic               last_1_o,
  output lsu_pkg::word_t     rdata_1_o,
  // Status
  output logic               busy_o,
  output logic               interruptible_o,
  output logic               protocol_err_o,
  // Data bus
  output logic               data_req_o,
  input  logic               data_gnt_i,
  output lsu_pkg::addr_t     data_addr_o,
  output logic               data_we_o,
  output lsu_pkg::be_t       data_be_o,
  output lsu_pkg::word_t     data_wdata_o,
  input  logic               data_rvalid_i,
  input  lsu_pkg::word_t     data_rdata_i
);

  import lsu_pkg::*;

  logic ex_done;
  logic txn_accept;

  assign data_we_o = we_i;

  ////////////////////////////////////////////////////////////////////////////
  // Stages
  ////////////////////////////////////////////////////////////////////////////

  lsu_req_gen u_req_gen (
    .clk          (clk),
    .rst_n        (rst_n),
    .valid_0_i    (valid_0_i),
    .op_a_i       (op_a_i),
    .op_b_i       (op_b_i),
    .wdata_i      (wdata_i),
    .size_i       (size_i),
    .ex_done_i    (ex_done),
    .trans_addr_o (data_addr_o),
    .trans_be_o   (data_be_o),
    .trans_wdata_o(data_wdata_o),
    .split_0_o    (split_0_o),
    .first_op_0_o (first_op_0_o),
    .last_op_0_o  (last_op_0_o),
    .misaligned_o ()
  );

  lsu_txn_ctrl #(
    .depth(LSU_DEPTH)
  ) u_txn_ctrl (
    .clk            (clk),
    .rst_n          (rst_n),
    .valid_0_i      (valid_0_i),
    .split_0_i      (split_0_o),
    .data_gnt_i     (data_gnt_i),
    .data_rvalid_i  (data_rvalid_i),
    .data_req_o     (data_req_o),
    .txn_accept_o   (txn_accept),
    .ex_done_o      (ex_done),
    .ready_0_o      (ready_0_o),
    .busy_o         (busy_o),
    .interruptible_o(interruptible_o),
    .protocol_err_o (protocol_err_o)
  );

  // Offset of each granted address as the split join needs the first one
  lsu_resp_align #(
    .depth(LSU_DEPTH)
  ) u_resp_align (
    .clk          (clk),
    .rst_n        (rst_n),
    .txn_accept_i (txn_accept),
    .split_0_i    (split_0_o),
    .we_i         (we_i),
    .size_i       (size_i),
    .sext_i       (sext_i),
    .offset_i     (data_addr_o[1:0]),
    .data_rvalid_i(data_rvalid_i),
    .data_rdata_i (data_rdata_i),
    .valid_1_o    (valid_1_o),
    .last_1_o     (last_1_o),
    .rdata_1_o    (rdata_1_o)
  );

endmodule

// File: logic/lsu_txn_ctrl.sv
// Bus transfer control: outstanding count, request gating, EX readiness and status flags
`timescale 1ns/1ps

module lsu_txn_ctrl #(
  parameter int unsigned depth = lsu_pkg::LSU_DEPTH
) (
  input  logic clk,
  input  logic rst_n,
  input  logic valid_0_i,
  input  logic split_0_i,
  input  logic data_gnt_i,
  input  logic data_rvalid_i,
  output logic data_req_o,
  output logic txn_accept_o,
  output logic ex_done_o,
  output logic ready_0_o,
  output logic busy_o,
  output logic interruptible_o,
  output logic protocol_err_o
);

  // Must hold 0 up to depth
  localparam int unsigned cnt_w = $clog2(depth + 1);
  localparam logic [cnt_w-1:0] cnt_max = cnt_w'(depth);

  logic [cnt_w-1:0] cnt_q;
  logic [cnt_w-1:0] cnt_d;
  logic             count_up;
  logic             count_down;
  // Request seen by the bus in an earlier cycle and not yet granted
  logic             req_stall_q;

  ////////////////////////////////////////////////////////////////////////////
  // Request and handshake
  ////////////////////////////////////////////////////////////////////////////

  // Never more than depth transfers waiting for data
  assign data_req_o   = valid_0_i && (cnt_q < cnt_max);
  assign txn_accept_o = data_req_o && data_gnt_i;

  // Address phase of EX finishes with the grant
  assign ex_done_o = txn_accept_o;

  // First half of a split keeps EX occupied for the second half
  assign ready_0_o = !valid_0_i || (txn_accept_o && !split_0_i);

  ////////////////////////////////////////////////////////////////////////////
  // Outstanding transfers
  ////////////////////////////////////////////////////////////////////////////

  assign count_up   = txn_accept_o;
  // A stray response must not wrap the counter
  assign count_down = data_rvalid_i && (cnt_q != '0);

  always_comb begin
    case ({count_up, count_down})
      2'b10:   cnt_d = cnt_q + 1'b1;
      2'b01:   cnt_d = cnt_q - 1'b1;
      default: cnt_d = cnt_q;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt_q <= '0;
    end else begin
      cnt_q <= cnt_d;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Status
  ////////////////////////////////////////////////////////////////////////////

  // Once the bus has seen the request it may not be withdrawn
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      req_stall_q <= 1'b0;
    end else if (!valid_0_i || txn_accept_o) begin
      req_stall_q <= 1'b0;
    end else if (data_req_o) begin
      req_stall_q <= 1'b1;
    end
  end

  assign busy_o          = (cnt_q != '0) || data_req_o;
  assign interruptible_o = !req_stall_q && (cnt_q == '0);

  // Response with nothing in flight
  assign protocol_err_o = data_rvalid_i && (cnt_q == '0);

  ////////////////////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////////////////////

  a_cnt_limit: assert property (@(posedge clk) disable iff (!rst_n)
    cnt_q <= cnt_max);

  // Bus rule, a pending request stays up until granted
  a_req_hold: assert property (@(posedge clk) disable iff (!rst_n)
    data_req_o && !data_gnt_i |=> data_req_o);

endmodule

// File: lsu.f
+incdir+bench
logic/lsu_pkg.sv
logic/lsu_req_gen.sv
logic/lsu_txn_ctrl.sv
logic/lsu_resp_align.sv
logic/lsu_top.sv
bench/lsu_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build the load/store unit testbench with Verilator, run it, and judge the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  -f lsu.f --top-module lsu_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/Vlsu_tb > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if grep -qx "NO ERRORS" "$LOG"; then
  echo "Result: pass"
  exit 0
fi
echo "Result: fail"
exit 1
